// ==== run_sim.sh ====
#!/bin/sh
# compile and run the multiplier testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module pu_mult_tb -f sources.f -o pu_mult_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/pu_mult_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

echo "simulation finished"
exit 0

// ==== sources.f ====
verilog/pu_pkg.sv
verilog/apb_pu_bridge.sv
verilog/pu_mult.sv
verilog/pu_mult_top.sv
verif/pu_mult_properties.sv
verif/pu_mult_tb.sv

// ==== verif/pu_mult_properties.sv ====
`timescale 1ns/1ps

module pu_mult_properties (
  input logic               clk,
  input logic               rst,
  input logic               oe,
  input pu_pkg::pu_cmd_t    cmd,
  input logic               busy,
  input pu_pkg::pu_result_t res
);

  logic start;
  logic seen_launch;

  // arg b write that raises the launch flag at the next edge
  assign start = cmd.wr & cmd.sel;

  always_ff @(posedge clk) begin
    if (rst) begin
      seen_launch <= 1'b0;
    end else if (start) begin
      seen_launch <= 1'b1;
    end
  end

  a_res_gated: assert property (@(posedge clk) disable iff (rst) !oe |-> res.data == '0)
    else $error("result data visible without oe");

  a_busy_after_launch: assert property (@(posedge clk) disable iff (rst) start |-> ##2 busy)
    else $error("busy missing one cycle after a launch");

  a_busy_only_after_launch: assert property (
    @(posedge clk) disable iff (rst) !start |-> ##2 !busy)
    else $error("busy high without a launch the cycle before");

  a_idle_after_reset: assert property (@(posedge clk) disable iff (rst) !seen_launch |-> !busy)
    else $error("busy high before the first launch");

endmodule

bind pu_mult pu_mult_properties u_props (
  .clk  (clk),
  .rst  (rst),
  .oe   (oe),
  .cmd  (cmd),
  .busy (busy),
  .res  (res)
);

// ==== verif/pu_mult_tb.sv ====
`timescale 1ns/1ps

module pu_mult_tb;

  localparam int clk_period = 40;
  localparam int n_iter     = 24; // random clean pairs.
  localparam int n_range    = 8;  // out of range pairs.
  localparam int n_trans    = 5 * (n_iter + n_range) + 40;
  localparam int max_cycles = n_trans * 4 + 8 + 50;

  logic        clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  integer seed;
  int     cycles = 0;

  // reference model state
  logic [31:0] m_arg [2];
  logic        m_inv [2];
  logic [31:0] m_data;
  logic        m_flag;

  pu_mult_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > max_cycles) begin
      $display("timeout: the test did not finish within %0d cycles", max_cycles);
      $display("test failed");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("test failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // one setup and one access cycle, entered and left 2 ns after an edge
  task automatic apb_xfer(input logic write, input logic [7:0] addr,
                          input logic [31:0] wdata, input logic exp_err,
                          output logic [31:0] rdata);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    @(negedge clk); // mid access phase.
    rdata = prdata;
    check_eq("pready", 32'(pready), 32'd1);
    check_eq("pslverr", 32'(pslverr), 32'(exp_err));
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_check(input logic [7:0] addr, input string name,
                            input logic [31:0] expected);
    logic [31:0] rdata;
    apb_xfer(1'b0, addr, 32'h0, 1'b0, rdata);
    check_eq(name, rdata, expected);
  endtask

  function automatic logic in_range(input logic [31:0] v);
    int s;
    s = v;
    return (s >= -32768) && (s <= 32767);
  endfunction

  function automatic logic [31:0] half_product(input logic [31:0] a, input logic [31:0] b);
    int sa;
    int sb;
    sa = {{16{a[15]}}, a[15:0]};
    sb = {{16{b[15]}}, b[15:0]};
    return sa * sb;
  endfunction

  function automatic logic [31:0] expected_status(input logic busy, input logic inv);
    logic [31:0] w;
    w = '0;
    w[pu_pkg::stat_busy_bit]    = busy;
    w[pu_pkg::stat_invalid_bit] = inv;
    return w;
  endfunction

  function automatic logic [31:0] rand_small();
    logic [31:0] r;
    r = $random(seed);
    return {{16{r[15]}}, r[15:0]};
  endfunction

  function automatic logic [31:0] rand_wide();
    logic [31:0] r;
    r = $random(seed);
    r[30] = ~r[31]; // top bits no longer a sign extension.
    return r;
  endfunction

  task automatic load_arg(input logic sel, input logic inv, input logic [31:0] value);
    logic [7:0]  addr;
    logic [31:0] rdata;
    if (sel) begin
      addr = inv ? pu_pkg::addr_arg_b_inv : pu_pkg::addr_arg_b;
    end else begin
      addr = inv ? pu_pkg::addr_arg_a_inv : pu_pkg::addr_arg_a;
    end
    apb_xfer(1'b1, addr, value, 1'b0, rdata);
    m_arg[sel] = value;
    m_inv[sel] = inv;
    if (sel) begin
      // old result still held while the launch is in stage 1
      read_check(pu_pkg::addr_status, "status while busy", expected_status(1'b1, m_flag));
      m_data = half_product(m_arg[0], m_arg[1]);
      m_flag = ~in_range(m_arg[0]) | ~in_range(m_arg[1]) | m_inv[0] | m_inv[1];
    end
  endtask

  task automatic check_result();
    read_check(pu_pkg::addr_result, "result", m_data);
    read_check(pu_pkg::addr_status, "status", expected_status(1'b0, m_flag));
  endtask

  initial begin
    logic [31:0] v;
    logic [31:0] rdata;
    seed     = 32'h3255;
    rst      = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    m_arg[0] = '0;
    m_arg[1] = '0;
    m_inv[0] = 1'b0;
    m_inv[1] = 1'b0;
    m_data   = '0;
    m_flag   = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;

    check_result(); // all zero after reset.

    for (int i = 0; i < n_iter; i++) begin
      load_arg(1'b0, 1'b0, rand_small());
      load_arg(1'b1, 1'b0, rand_small());
      check_result();
    end

    for (int i = 0; i < n_range; i++) begin
      v = $random(seed);
      load_arg(1'b0, 1'b0, v[0] ? rand_wide() : rand_small());
      load_arg(1'b1, 1'b0, v[0] ? rand_small() : rand_wide());
      check_result();
    end

    // invalid attribute through the _inv addresses.
    load_arg(1'b0, 1'b1, rand_small());
    load_arg(1'b1, 1'b0, rand_small());
    check_result();
    load_arg(1'b0, 1'b0, rand_small());
    load_arg(1'b1, 1'b1, rand_small());
    check_result();
    load_arg(1'b0, 1'b0, rand_small());
    load_arg(1'b1, 1'b0, rand_small());
    check_result();

    // bad accesses give pslverr and leave the result alone
    v = $random(seed);
    apb_xfer(1'b1, pu_pkg::addr_result, v, 1'b1, rdata);
    apb_xfer(1'b1, pu_pkg::addr_status, v, 1'b1, rdata);
    apb_xfer(1'b1, 8'h18, v, 1'b1, rdata);
    apb_xfer(1'b0, 8'h18, 32'h0, 1'b1, rdata);
    apb_xfer(1'b1, 8'h01, v, 1'b1, rdata);
    apb_xfer(1'b0, 8'hFC, 32'h0, 1'b1, rdata);
    check_result();

    for (int i = 0; i < 3; i++) begin
      load_arg(1'b1, 1'b0, rand_small()); // arg a kept.
      check_result();
    end

    $display("test passed");
    $finish;
  end

endmodule

// ==== verilog/apb_pu_bridge.sv ====
`timescale 1ns/1ps

module apb_pu_bridge (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [pu_pkg::addr_w-1:0] paddr,
  input  logic [pu_pkg::data_w-1:0] pwdata,
  output logic [pu_pkg::data_w-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,
  output pu_pkg::pu_cmd_t           cmd,
  output logic                      oe,
  output logic                      status_oe,
  input  pu_pkg::pu_result_t        res,
  input  logic                      busy
);

  pu_pkg::pu_op_e            op;
  logic                      setup_q;
  logic                      access;
  logic                      inv_addr;
  logic [pu_pkg::data_w-1:0] status_word;

  // remembers that the transfer went through a setup cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= psel & ~penable;
    end
  end

  assign access = psel & penable & setup_q;
  assign pready = psel & penable; // no wait states.

  always_comb begin
    op       = pu_pkg::op_none;
    inv_addr = 1'b0;
    if (psel) begin
      case (paddr)
        pu_pkg::addr_arg_a, pu_pkg::addr_arg_a_inv: begin
          if (pwrite) begin
            op = pu_pkg::op_load_a;
          end
        end
        pu_pkg::addr_arg_b, pu_pkg::addr_arg_b_inv: begin
          if (pwrite) begin
            op = pu_pkg::op_load_b;
          end
        end
        pu_pkg::addr_result: begin
          op = pwrite ? pu_pkg::op_bad : pu_pkg::op_read_result;
        end
        pu_pkg::addr_status: begin
          op = pwrite ? pu_pkg::op_bad : pu_pkg::op_read_status;
        end
        default: begin
          op = pu_pkg::op_bad; // unknown address.
        end
      endcase
      inv_addr = (paddr == pu_pkg::addr_arg_a_inv) || (paddr == pu_pkg::addr_arg_b_inv);
    end
  end

  always_comb begin
    cmd      = '0;
    cmd.wr   = access & ((op == pu_pkg::op_load_a) | (op == pu_pkg::op_load_b));
    cmd.sel  = (op == pu_pkg::op_load_b);
    cmd.data = pwdata;
    cmd.attr[pu_pkg::invalid_bit] = inv_addr;
  end

  assign oe        = access & (op == pu_pkg::op_read_result);
  assign status_oe = access & (op == pu_pkg::op_read_status);
  assign pslverr   = access & (op == pu_pkg::op_bad);

  always_comb begin
    status_word = '0;
    status_word[pu_pkg::stat_invalid_bit] = res.attr[pu_pkg::invalid_bit];
    status_word[pu_pkg::stat_busy_bit]    = busy;
  end

  always_comb begin
    if (oe) begin
      prdata = res.data;
    end else if (status_oe) begin
      prdata = status_word;
    end else begin
      prdata = '0;
    end
  end

endmodule

// ==== verilog/pu_mult.sv ====
`timescale 1ns/1ps

module pu_mult (
  input  logic               clk,
  input  logic               rst,
  input  pu_pkg::pu_cmd_t    cmd,
  input  logic               oe,
  input  logic               status_oe,
  output pu_pkg::pu_result_t res,
  output logic               busy
);

  // captured arguments of stage 0
  logic [pu_pkg::data_w-1:0] arg     [2];
  logic                      arg_inv [2];
  logic                      launch;

  logic signed [pu_pkg::data_w-1:0] prod;
  logic                             range_bad;
  logic                             attr_bad;

  // stage 1
  logic signed [pu_pkg::data_w-1:0] s1_prod;
  logic                             s1_inv;
  logic                             s1_vld;
  logic [pu_pkg::attr_w:0]          s1_attr;

  // result register of stage 2
  pu_pkg::pu_result_t result_q;

  // top half_w+1 bits must be a pure sign extension
  function automatic logic fits_half(input logic [pu_pkg::data_w-1:0] v);
    logic [pu_pkg::half_w:0] top;
    top = v[pu_pkg::data_w-1:pu_pkg::half_w-1];
    return (top == '0) || (top == '1);
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      arg[0]     <= '0;
      arg[1]     <= '0;
      arg_inv[0] <= 1'b0;
      arg_inv[1] <= 1'b0;
      launch     <= 1'b0;
    end else begin
      launch <= cmd.wr & cmd.sel; // arg b write starts a multiply.
      if (cmd.wr) begin
        arg[cmd.sel]     <= cmd.data;
        arg_inv[cmd.sel] <= cmd.attr[pu_pkg::invalid_bit];
      end
    end
  end

  assign prod = $signed(arg[0][pu_pkg::half_w-1:0]) * $signed(arg[1][pu_pkg::half_w-1:0]);

  assign range_bad = ~fits_half(arg[0]) | ~fits_half(arg[1]);
  assign attr_bad  = arg_inv[0] | arg_inv[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_prod <= '0;
      s1_inv  <= 1'b0;
      s1_vld  <= 1'b0;
    end else begin
      s1_vld <= launch;
      if (launch) begin
        s1_prod <= prod;
        s1_inv  <= range_bad | attr_bad;
      end
    end
  end

  assign busy = s1_vld; // a launch sits in stage 1.

  always_comb begin
    s1_attr = '0;
    s1_attr[pu_pkg::invalid_bit] = s1_inv;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_q <= '0;
    end else if (s1_vld) begin
      result_q.data <= s1_prod;
      result_q.attr <= s1_attr;
    end
  end

  // the flag goes out on both reads and the data only on result reads
  always_comb begin
    res = '0;
    if (oe) begin
      res.data = result_q.data;
    end
    if (oe | status_oe) begin
      res.attr[pu_pkg::invalid_bit] = result_q.attr[pu_pkg::invalid_bit];
    end
  end

endmodule

// ==== verilog/pu_mult_top.sv ====
`timescale 1ns/1ps

module pu_mult_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [pu_pkg::addr_w-1:0] paddr,
  input  logic [pu_pkg::data_w-1:0] pwdata,
  output logic [pu_pkg::data_w-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr
);

  pu_pkg::pu_cmd_t    cmd;
  pu_pkg::pu_result_t res;
  logic               oe;
  logic               status_oe;
  logic               busy;

  apb_pu_bridge u_bridge (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .cmd       (cmd),
    .oe        (oe),
    .status_oe (status_oe),
    .res       (res),
    .busy      (busy)
  );

  pu_mult u_mult (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd),
    .oe        (oe),
    .status_oe (status_oe),
    .res       (res),
    .busy      (busy)
  );

endmodule

// ==== verilog/pu_pkg.sv ====
package pu_pkg;

  localparam int data_w      = 32; // data word width.
  localparam int attr_w      = 4;  // attribute field is attr_w+1 bits.
  localparam int invalid_bit = 0;  // invalid attribute position.
  localparam int half_w      = 16; // signed operand width.
  localparam int addr_w      = 8;  // apb address width.

  // register map of the multiplier unit
  localparam logic [addr_w-1:0] addr_arg_a     = 8'h00;
  localparam logic [addr_w-1:0] addr_arg_b     = 8'h04;
  localparam logic [addr_w-1:0] addr_result    = 8'h08; // read only.
  localparam logic [addr_w-1:0] addr_status    = 8'h0C; // read only.
  localparam logic [addr_w-1:0] addr_arg_a_inv = 8'h10;
  localparam logic [addr_w-1:0] addr_arg_b_inv = 8'h14;

  // status word layout.
  localparam int stat_invalid_bit = 0;
  localparam int stat_busy_bit    = 1;

  typedef enum logic [2:0] {
    op_none,
    op_load_a,
    op_load_b,
    op_read_result,
    op_read_status,
    op_bad
  } pu_op_e;

  // command from the bridge into a processing unit
  typedef struct packed {
    logic              wr;   // write strobe.
    logic              sel;  // 1 selects arg b and launches.
    logic [data_w-1:0] data;
    logic [attr_w:0]   attr;
  } pu_cmd_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [attr_w:0]   attr;
  } pu_result_t;

endpackage
